// ==== hdl/bt_rx_pkg.sv ====
// Shared widths, types, state enums, commands and register map for the receiver.
`default_nettype none

package bt_rx_pkg;

	localparam int FIFO_DEPTH = 64;                  // Receive FIFO depth in bytes.
	localparam int FIFO_ADDR_W = $clog2(FIFO_DEPTH); // Byte pointer width.

	typedef logic [7:0] byte_t;                      // One serial byte.
	typedef logic [15:0] word_t;                     // Two bytes, first one low.
	typedef logic [9:0] bit_period_t;                // Clock cycles per serial bit.
	typedef logic [9:0] gap_t;                       // Idle cycles that close a message.
	typedef logic [FIFO_ADDR_W-1:0] fifo_ptr_t;      // FIFO memory index.
	typedef logic [FIFO_ADDR_W:0] fifo_count_t;      // Byte count, holds FIFO_DEPTH.
	typedef logic [7:0] apb_addr_t;
	typedef logic [31:0] apb_data_t;

	typedef enum logic [1:0] {UART_IDLE, UART_START, UART_DATA, UART_STOP} uart_state_t;

	typedef enum logic [1:0] {FRAME_COLLECTING, FRAME_CHECKING_GAP, FRAME_DONE} frame_state_t;

	// Data-stream pair capture.
	typedef enum logic {DS_WANT_COMMAND, DS_WANT_OPERAND} ds_state_t;

	localparam byte_t CMD_START = 8'h00;             // Operand picks the stream.
	localparam byte_t CMD_CANCEL = 8'h01;

	// Host register map.
	localparam apb_addr_t REG_CTRL = 8'h00;          // Bit 0 selects AT mode.
	localparam apb_addr_t REG_BIT_PERIOD = 8'h04;
	localparam apb_addr_t REG_GAP = 8'h08;
	localparam apb_addr_t REG_STATUS = 8'h0C;
	localparam apb_addr_t REG_RDATA = 8'h10;         // Read pops one word.

	localparam bit_period_t BIT_PERIOD_RESET = 10'd16;
	localparam gap_t GAP_RESET = 10'd200;

endpackage

`default_nettype wire

// ==== hdl/rx_byte_if.sv ====
// Byte and line status interface between the UART receiver and the message framer.
`timescale 1ns/1ps
`default_nettype none

interface rx_byte_if import bt_rx_pkg::*; ();

	byte_t data;       // Last assembled byte.
	logic valid;       // One cycle, good stop bit.
	logic collecting;  // A byte is on the line.
	logic stop_error;  // One cycle, stop bit was low.

	// Receiver side.
	modport uart (output data, valid, collecting, stop_error);

	// Framer side.
	modport framer (input data, valid, collecting, stop_error);

endinterface

`default_nettype wire

// ==== hdl/fifo_rd_if.sv ====
// Read side interface between the receive FIFO and the APB register block.
`timescale 1ns/1ps
`default_nettype none

interface fifo_rd_if import bt_rx_pkg::*; ();

	logic pop;                // Take two bytes this edge.
	word_t word;              // Oldest pair, shown combinationally.
	fifo_count_t word_count;  // Whole words held.
	logic empty;
	logic full;

	// FIFO side.
	modport buffer (input pop, output word, word_count, empty, full);

	// Register block side.
	modport host (output pop, input word, word_count, empty, full);

endinterface

`default_nettype wire

// ==== hdl/uart_rx.sv ====
// UART receiver, 8N1, sampling each bit at its centre with a programmable bit period.
`timescale 1ns/1ps
`default_nettype none

module uart_rx import bt_rx_pkg::*; (
	input wire clock,
	input wire reset,
	input wire rxd,
	input wire bit_period_t bit_period,
	rx_byte_if.uart rx
);

	uart_state_t state;
	bit_period_t count;      // Cycles into the current bit.
	logic [2:0] bit_index;   // Data bit being sampled.
	byte_t shift;            // LSB first shift register.
	logic [1:0] rxd_sync;    // Line synchroniser.
	logic rxd_prev;
	logic rxd_s;
	logic start_edge;
	logic half_done;
	logic bit_done;

	assign rxd_s = rxd_sync[1];
	assign start_edge = rxd_prev & ~rxd_s;              // Falling edge opens a byte.
	assign half_done = (count == (bit_period >> 1));    // Centre of the start bit.
	assign bit_done = (count == bit_period - 1'b1);     // One whole period later.

	assign rx.data = shift;
	assign rx.collecting = (state != UART_IDLE);

	// Line idles high.
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			rxd_sync <= 2'b11;
			rxd_prev <= 1'b1;
		end
		else
		begin
			rxd_sync <= {rxd_sync[0], rxd};
			rxd_prev <= rxd_s;
		end
	end

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			state <= UART_IDLE;
			count <= '0;
			bit_index <= '0;
			rx.valid <= 1'b0;
			rx.stop_error <= 1'b0;
		end
		else
		begin
			rx.valid <= 1'b0;      // Strobes last one cycle.
			rx.stop_error <= 1'b0;
			case (state)
				UART_IDLE:
				begin
					count <= '0;
					if (start_edge)
						state <= UART_START;
				end
				UART_START:
				begin
					if (half_done)
					begin
						count <= '0;
						bit_index <= '0;
						// A glitch that is high again at mid bit is ignored.
						state <= rxd_s ? UART_IDLE : UART_DATA;
					end
					else
						count <= count + 1'b1;
				end
				UART_DATA:
				begin
					if (bit_done)
					begin
						count <= '0;
						bit_index <= bit_index + 1'b1;
						if (bit_index == 3'd7)
							state <= UART_STOP;
					end
					else
						count <= count + 1'b1;
				end
				UART_STOP:
				begin
					if (bit_done)
					begin
						count <= '0;
						state <= UART_IDLE;     // Back in time for the next start edge.
						rx.valid <= rxd_s;
						rx.stop_error <= ~rxd_s; // Framing error, byte dropped.
					end
					else
						count <= count + 1'b1;
				end
				default:
					state <= UART_IDLE;
			endcase
		end
	end

	// Sample at the centre of each data bit.
	always_ff @(posedge clock)
	begin
		if (state == UART_DATA && bit_done)
			shift <= {rxd_s, shift[7:1]};
	end

endmodule

`default_nettype wire

// ==== hdl/msg_framer.sv ====
// Message framer: gap timer, AT/data-stream routing, command capture and stream decode.
`timescale 1ns/1ps
`default_nettype none

module msg_framer import bt_rx_pkg::*; (
	input wire clock,
	input wire reset,
	rx_byte_if.framer rx,
	input wire want_at,
	input wire gap_t gap,
	output logic wr_en,
	output byte_t wr_data,
	output logic at_response_pulse,
	output logic ds_sending,
	output byte_t stream_select
);

	frame_state_t frame_state;
	gap_t gap_timer;         // Idle cycles since the last byte.
	ds_state_t ds_state;
	byte_t command;
	byte_t operand;
	logic msg_done;
	logic ds_byte;

	assign msg_done = (frame_state == FRAME_DONE);
	assign ds_byte = rx.valid & ~want_at;

	// AT mode bytes go straight to the FIFO.
	assign wr_en = rx.valid & want_at;
	assign wr_data = rx.data;
	assign at_response_pulse = msg_done & want_at;

	// Gap machine.
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			frame_state <= FRAME_COLLECTING;
			gap_timer <= '0;
		end
		else
		begin
			case (frame_state)
				FRAME_COLLECTING:
				begin
					gap_timer <= '0;
					if (rx.valid)
						frame_state <= FRAME_CHECKING_GAP;
				end
				FRAME_CHECKING_GAP:
				begin
					if (rx.collecting)
						frame_state <= FRAME_COLLECTING;  // Another byte, same message.
					else if (gap_timer == gap)
						frame_state <= FRAME_DONE;
					else
						gap_timer <= gap_timer + 1'b1;
				end
				FRAME_DONE:
					frame_state <= FRAME_COLLECTING;    // Single cycle.
				default:
					frame_state <= FRAME_COLLECTING;
			endcase
		end
	end

	// Command then operand, alternating.
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
			ds_state <= DS_WANT_COMMAND;
		else if (msg_done || rx.stop_error)
			ds_state <= DS_WANT_COMMAND;  // Realign on message end or bad byte.
		else if (ds_byte)
			ds_state <= (ds_state == DS_WANT_COMMAND) ? DS_WANT_OPERAND : DS_WANT_COMMAND;
	end

	always_ff @(posedge clock)
	begin
		if (ds_byte && ds_state == DS_WANT_COMMAND)
			command <= rx.data;
		if (ds_byte && ds_state == DS_WANT_OPERAND)
			operand <= rx.data;
	end

	// Decode on the done cycle, visible one cycle later.
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			stream_select <= '0;
			ds_sending <= 1'b0;
		end
		else if (msg_done && !want_at)
		begin
			case (command)
				CMD_START:
				begin
					if (operand == '0)
					begin
						stream_select <= '0;   // Start with no stream stops all.
						ds_sending <= 1'b0;
					end
					else
					begin
						stream_select <= operand;
						ds_sending <= 1'b1;
					end
				end
				CMD_CANCEL:
					ds_sending <= 1'b0;         // Select is kept.
				default:
					;                           // Unknown command.
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hdl/rx_byte_fifo.sv ====
// Receive FIFO, one byte in per write and two bytes out per pop.
`timescale 1ns/1ps
`default_nettype none

module rx_byte_fifo import bt_rx_pkg::*; (
	input wire clock,
	input wire reset,
	input wire wr_en,
	input wire byte_t wr_data,
	fifo_rd_if.buffer rd
);

	byte_t mem [FIFO_DEPTH];
	fifo_ptr_t wr_ptr;
	fifo_ptr_t rd_ptr;        // Always even.
	fifo_ptr_t rd_ptr_high;   // Second byte of the pair.
	fifo_count_t count;       // Bytes held.
	logic push;
	logic pull;

	assign push = wr_en & ~rd.full;                  // Dropped when full.
	assign pull = rd.pop & (rd.word_count != '0);
	assign rd_ptr_high = rd_ptr + 1'b1;

	always_ff @(posedge clock)
	begin
		if (push)
			mem[wr_ptr] <= wr_data;
	end

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pull)
				rd_ptr <= rd_ptr + 2'd2;
			count <= count + fifo_count_t'(push) - (pull ? fifo_count_t'(2) : '0);
		end
	end

	// First byte received sits in the low half.
	assign rd.word = {mem[rd_ptr_high], mem[rd_ptr]};
	assign rd.word_count = count >> 1;
	assign rd.empty = (rd.word_count == '0);       // A lone byte still reads as empty.
	assign rd.full = (count == fifo_count_t'(FIFO_DEPTH));

endmodule

`default_nettype wire

// ==== hdl/rx_apb_regs.sv ====
// APB slave holding mode, timing, sticky status and the FIFO read port.
`timescale 1ns/1ps
`default_nettype none

module rx_apb_regs import bt_rx_pkg::*; (
	input wire clock,
	input wire reset,
	input wire apb_addr_t paddr,
	input wire psel,
	input wire penable,
	input wire pwrite,
	input wire apb_data_t pwdata,
	output apb_data_t prdata,
	output logic pready,
	output logic pslverr,
	output logic want_at,
	output bit_period_t bit_period,
	output gap_t gap,
	output logic at_response,
	input wire at_response_pulse,
	input wire ds_sending,
	input wire byte_t stream_select,
	fifo_rd_if.host rd
);

	logic access;
	logic wr_access;
	logic rdata_read;
	logic has_word;
	apb_data_t status;

	assign access = psel & penable;          // Access phase.
	assign wr_access = access & pwrite;
	assign rdata_read = access & ~pwrite & (paddr == REG_RDATA);
	assign has_word = (rd.word_count != '0);

	assign pready = 1'b1;                    // No wait states.
	assign rd.pop = rdata_read & has_word;
	assign pslverr = rdata_read & ~has_word; // Underflow.

	// Configuration, AT mode out of reset.
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			want_at <= 1'b1;
			bit_period <= BIT_PERIOD_RESET;
			gap <= GAP_RESET;
		end
		else if (wr_access)
		begin
			case (paddr)
				REG_CTRL:
					want_at <= pwdata[0];
				REG_BIT_PERIOD:
					bit_period <= bit_period_t'(pwdata);
				REG_GAP:
					gap <= gap_t'(pwdata);
				default:
					;
			endcase
		end
	end

	// Sticky AT response, write one to clear.
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
			at_response <= 1'b0;
		else if (at_response_pulse)
			at_response <= 1'b1;    // New event wins over a clear.
		else if (wr_access && paddr == REG_STATUS && pwdata[2])
			at_response <= 1'b0;
	end

	always_comb
	begin
		status = '0;
		status[0] = rd.empty;
		status[1] = rd.full;
		status[2] = at_response;
		status[3] = ds_sending;
		status[15:8] = stream_select;
		status[31:24] = 8'(rd.word_count);
	end

	// Read mux, unmapped reads return zero.
	always_comb
	begin
		case (paddr)
			REG_CTRL:
				prdata = apb_data_t'(want_at);
			REG_BIT_PERIOD:
				prdata = apb_data_t'(bit_period);
			REG_GAP:
				prdata = apb_data_t'(gap);
			REG_STATUS:
				prdata = status;
			REG_RDATA:
				prdata = has_word ? apb_data_t'(rd.word) : '0;
			default:
				prdata = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== hdl/bt_receiver.sv ====
// Top level of the receive bridge: UART, framer, FIFO and APB registers.
`timescale 1ns/1ps
`default_nettype none

module bt_receiver import bt_rx_pkg::*; (
	input wire clock,
	input wire reset,
	input wire rxd,
	input wire apb_addr_t paddr,
	input wire psel,
	input wire penable,
	input wire pwrite,
	input wire apb_data_t pwdata,
	output apb_data_t prdata,
	output logic pready,
	output logic pslverr,
	output logic at_response,
	output logic ds_sending,
	output byte_t stream_select
);

	rx_byte_if rx_bytes ();
	fifo_rd_if fifo_rd ();

	logic want_at;
	bit_period_t bit_period;
	gap_t gap;
	logic wr_en;            // AT mode byte write.
	byte_t wr_data;
	logic at_response_pulse;

	uart_rx u_uart_rx (
		.clock      (clock),
		.reset      (reset),
		.rxd        (rxd),
		.bit_period (bit_period),
		.rx         (rx_bytes.uart)
	);

	msg_framer u_msg_framer (
		.clock             (clock),
		.reset             (reset),
		.rx                (rx_bytes.framer),
		.want_at           (want_at),
		.gap               (gap),
		.wr_en             (wr_en),
		.wr_data           (wr_data),
		.at_response_pulse (at_response_pulse),
		.ds_sending        (ds_sending),
		.stream_select     (stream_select)
	);

	rx_byte_fifo u_rx_byte_fifo (
		.clock   (clock),
		.reset   (reset),
		.wr_en   (wr_en),
		.wr_data (wr_data),
		.rd      (fifo_rd.buffer)
	);

	// Host side, at_response here is the sticky copy.
	rx_apb_regs u_rx_apb_regs (
		.clock             (clock),
		.reset             (reset),
		.paddr             (paddr),
		.psel              (psel),
		.penable           (penable),
		.pwrite            (pwrite),
		.pwdata            (pwdata),
		.prdata            (prdata),
		.pready            (pready),
		.pslverr           (pslverr),
		.want_at           (want_at),
		.bit_period        (bit_period),
		.gap               (gap),
		.at_response       (at_response),
		.at_response_pulse (at_response_pulse),
		.ds_sending        (ds_sending),
		.stream_select     (stream_select),
		.rd                (fifo_rd.host)
	);

endmodule

`default_nettype wire

// ==== include/tb_util.svh ====
// LFSR byte source, value check, run abort, APB transfers and UART line driving.
`ifndef TB_UTIL_SVH
`define TB_UTIL_SVH

// Galois LFSR, one step per bit.
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
	return state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);
endfunction

task automatic next_random_byte(output byte_t value);
	value = '0;
	repeat (8)
	begin
		lfsr = lfsr_next(lfsr);
		value = {value[6:0], lfsr[0]};  // One bit per step.
	end
endtask

task automatic stop_run(input string reason);
	$display("%s", reason);
	$display(">>> FAIL");
	$fatal(1, "Run stopped at the first error.");
endtask

task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] expected);
	if (got !== expected)
		stop_run($sformatf("FAIL %s got %h expected %h", name, got, expected));
endtask

// Setup phase, then access phase. The write lands on the rise in between.
task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
	@(negedge clock);
	psel = 1'b1;
	penable = 1'b0;
	pwrite = 1'b1;
	paddr = addr;
	pwdata = data;
	@(negedge clock);
	penable = 1'b1;
	@(negedge clock);
	psel = 1'b0;
	penable = 1'b0;
	pwrite = 1'b0;
endtask

task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err);
	@(negedge clock);
	psel = 1'b1;
	penable = 1'b0;
	pwrite = 1'b0;
	paddr = addr;
	@(negedge clock);
	penable = 1'b1;
	#SAMPLE_DELAY;        // Settled, still before the pop edge.
	data = prdata;
	err = pslverr;
	@(negedge clock);
	psel = 1'b0;
	penable = 1'b0;
endtask

// 8N1 frame, LSB first. Starts and ends on a falling clock edge.
task automatic send_byte(input byte_t value);
	byte_t bits;
	bits = value;
	rxd = 1'b0;           // Start bit.
	repeat (bit_period_cfg) @(negedge clock);
	repeat (8)
	begin
		rxd = bits[0];
		bits = bits >> 1;
		repeat (bit_period_cfg) @(negedge clock);
	end
	rxd = 1'b1;           // Stop bit, then idle.
	repeat (bit_period_cfg) @(negedge clock);
endtask

// No idle time between frames.
task automatic send_burst(input byte_t bytes[$]);
	@(negedge clock);
	foreach (bytes[k])
		send_byte(bytes[k]);
endtask

`endif

// ==== test/tb_bt_receiver.sv ====
// Testbench for the receive bridge: clock, reset, watchdog, DUT and directed tests.
`timescale 1ns/1ps
`default_nettype none

module tb_bt_receiver import bt_rx_pkg::*; ();

	localparam int CLK_PERIOD = 10;
	localparam int RESET_CYCLES = 16;
	localparam int SAMPLE_DELAY = 2;
	localparam int TOTAL_BYTES = 88;    // Sent over all tests.
	localparam int MESSAGES = 8;
	localparam int APB_CYCLES = 2000;   // Register traffic allowance.
	localparam int WATCHDOG_CYCLES = 2 * (TOTAL_BYTES * 12 * int'(BIT_PERIOD_RESET)
		+ MESSAGES * int'(GAP_RESET) + APB_CYCLES) + RESET_CYCLES;

	logic clock;
	logic reset;
	logic rxd;
	apb_addr_t paddr;
	logic psel;
	logic penable;
	logic pwrite;
	apb_data_t pwdata;
	apb_data_t prdata;
	logic pready;
	logic pslverr;
	logic at_response;
	logic ds_sending;
	byte_t stream_select;

	logic [31:0] lfsr;            // Random byte source state.
	bit_period_t bit_period_cfg;  // Mirror of the programmed timing.
	gap_t gap_cfg;
	int cycle_count;
	byte_t sent[$];               // Bytes of the current burst.

	bt_receiver dut_i (.*);

	`include "tb_util.svh"

	initial
		clock = 1'b0;
	always #(CLK_PERIOD / 2) clock = ~clock;

	always @(posedge clock)
		cycle_count <= cycle_count + 1;

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clock);
		stop_run("Watchdog expired before the tests finished.");
	end

	task automatic fill_random(input int count);
		byte_t value;
		int i;
		sent.delete();
		for (i = 0; i < count; i++)
		begin
			next_random_byte(value);
			sent.push_back(value);
		end
	endtask

	// Polls STATUS until the masked bits match, bounded by the gap.
	task automatic wait_status(input apb_data_t mask, input apb_data_t value, input string what);
		apb_data_t status;
		logic err;
		int polls;
		polls = 0;
		apb_read(REG_STATUS, status, err);
		while ((status & mask) != value)
		begin
			polls++;
			if (polls > int'(gap_cfg) + 64)
				stop_run($sformatf("Timed out waiting for %s in STATUS.", what));
			apb_read(REG_STATUS, status, err);
		end
	endtask

	task automatic read_word(input word_t expected);
		apb_data_t value;
		logic err;
		apb_read(REG_RDATA, value, err);
		check_eq("rdata", value, 32'(expected));
		check_eq("pslverr", 32'(err), 32'd0);
	endtask

	task automatic test_reset_config();
		apb_data_t value;
		logic err;
		apb_read(REG_STATUS, value, err);
		check_eq("status.empty", 32'(value[0]), 32'd1);
		check_eq("status.full", 32'(value[1]), 32'd0);
		check_eq("status.at_response", 32'(value[2]), 32'd0);
		check_eq("status.ds_sending", 32'(value[3]), 32'd0);
		check_eq("pslverr", 32'(err), 32'd0);
		check_eq("pready", 32'(pready), 32'd1);
		check_eq("at_response", 32'(at_response), 32'd0);
		check_eq("ds_sending", 32'(ds_sending), 32'd0);
		check_eq("stream_select", 32'(stream_select), 32'd0);
		apb_read(REG_BIT_PERIOD, value, err);
		check_eq("bit_period", value, 32'(BIT_PERIOD_RESET));
		apb_read(REG_GAP, value, err);
		check_eq("gap", value, 32'(GAP_RESET));
		apb_write(REG_BIT_PERIOD, 32'd8);
		apb_write(REG_GAP, 32'd150);
		apb_read(REG_BIT_PERIOD, value, err);
		check_eq("bit_period", value, 32'd8);
		apb_read(REG_GAP, value, err);
		check_eq("gap", value, 32'd150);
		bit_period_cfg = 10'd8;
		gap_cfg = 10'd150;
	endtask

	task automatic test_at_packing();
		apb_data_t status;
		logic err;
		int i;
		fill_random(6);
		send_burst(sent);
		wait_status(32'h4, 32'h4, "at_response");
		check_eq("at_response", 32'(at_response), 32'd1);
		for (i = 0; i < 6; i += 2)
			read_word({sent[i + 1], sent[i]});   // First byte low.
		apb_read(REG_STATUS, status, err);
		check_eq("status.empty", 32'(status[0]), 32'd1);
		apb_write(REG_STATUS, 32'h4);            // Write one to clear.
		apb_read(REG_STATUS, status, err);
		check_eq("status.at_response", 32'(status[2]), 32'd0);
	endtask

	task automatic test_gap_rule();
		apb_data_t status;
		logic err;
		logic burst_done;
		int start;
		fill_random(4);
		burst_done = 1'b0;
		fork
			begin
				send_burst(sent);
				burst_done = 1'b1;
			end
			// Bytes keep coming, so the message stays open.
			while (!burst_done)
			begin
				apb_read(REG_STATUS, status, err);
				check_eq("status.at_response", 32'(status[2]), 32'd0);
			end
		join
		start = cycle_count;
		wait_status(32'h4, 32'h4, "at_response after the burst");
		// Gap counts from the middle of the last stop bit.
		if (cycle_count - start < int'(gap_cfg) - int'(bit_period_cfg))
			stop_run("at_response rose before the line had been idle for the gap.");
		read_word({sent[1], sent[0]});
		read_word({sent[3], sent[2]});
		apb_write(REG_STATUS, 32'h4);
	endtask

	task automatic ds_message(input byte_t command, input byte_t operand);
		sent.delete();
		sent.push_back(command);
		sent.push_back(operand);
		send_burst(sent);
	endtask

	task automatic check_stream(input logic sending, input byte_t select);
		apb_data_t status;
		logic err;
		apb_read(REG_STATUS, status, err);
		check_eq("status.ds_sending", 32'(status[3]), 32'(sending));
		check_eq("status.stream_select", 32'(status[15:8]), 32'(select));
		check_eq("status.empty", 32'(status[0]), 32'd1);     // Nothing reaches the FIFO.
		check_eq("status.word_count", 32'(status[31:24]), 32'd0);
		check_eq("status.at_response", 32'(status[2]), 32'd0);
		check_eq("ds_sending", 32'(ds_sending), 32'(sending));
		check_eq("stream_select", 32'(stream_select), 32'(select));
	endtask

	task automatic test_data_stream();
		apb_write(REG_CTRL, 32'd0);
		ds_message(CMD_START, 8'h5A);
		wait_status(32'hFF08, 32'h5A08, "stream 0x5A");
		check_stream(1'b1, 8'h5A);
		ds_message(CMD_CANCEL, 8'h00);
		wait_status(32'h8, 32'h0, "cancel");
		check_stream(1'b0, 8'h5A);                          // Select kept.
		ds_message(CMD_START, 8'h33);
		wait_status(32'hFF08, 32'h3308, "stream 0x33");
		ds_message(8'h7E, 8'h11);
		// Unknown command gives no event, so let the gap run out.
		repeat (int'(gap_cfg) + 4 * int'(bit_period_cfg)) @(negedge clock);
		check_stream(1'b1, 8'h33);
		ds_message(CMD_START, 8'h00);
		wait_status(32'hFF08, 32'h0, "stop of all streams");
		check_stream(1'b0, 8'h00);
	endtask

	task automatic test_overflow();
		apb_data_t value;
		logic err;
		int i;
		apb_write(REG_CTRL, 32'd1);
		fill_random(FIFO_DEPTH + 4);
		send_burst(sent);
		wait_status(32'h4, 32'h4, "at_response after the long burst");
		apb_read(REG_STATUS, value, err);
		check_eq("status.full", 32'(value[1]), 32'd1);
		check_eq("status.word_count", 32'(value[31:24]), 32'(FIFO_DEPTH / 2));
		for (i = 0; i < FIFO_DEPTH; i += 2)
			read_word({sent[i + 1], sent[i]});             // Last four bytes were lost.
		apb_read(REG_STATUS, value, err);
		check_eq("status.empty", 32'(value[0]), 32'd1);
		apb_read(REG_RDATA, value, err);
		check_eq("pslverr", 32'(err), 32'd1);               // Underflow.
		check_eq("rdata", value, 32'd0);
	endtask

	initial
	begin
		rxd = 1'b1;                 // Line idles high.
		paddr = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		pwdata = '0;
		lfsr = 32'h2cc509ae;
		bit_period_cfg = BIT_PERIOD_RESET;
		gap_cfg = GAP_RESET;
		reset = 1'b1;
		repeat (RESET_CYCLES) @(negedge clock);
		reset = 1'b0;
		test_reset_config();
		test_at_packing();
		test_gap_rule();
		test_data_stream();
		test_overflow();
		$display(">>> PASS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== files.f ====
hdl/bt_rx_pkg.sv
hdl/rx_byte_if.sv
hdl/fifo_rd_if.sv
hdl/uart_rx.sv
hdl/msg_framer.sv
hdl/rx_byte_fifo.sv
hdl/rx_apb_regs.sv
hdl/bt_receiver.sv
+incdir+include
test/tb_bt_receiver.sv

// ==== Makefile ====
# Verilator flow for the receive bridge and its testbench.
TOP := tb_bt_receiver

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -f files.f --top-module bt_receiver
	verilator --lint-only --timing --timescale 1ns/1ps -f files.f --top-module $(TOP)

# The testbench ends every failing run with $$fatal, so the exit status carries the result.
sim:
	verilator --binary --timing --timescale 1ns/1ps -j 0 -f files.f \
		--top-module $(TOP) --Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP)

clean:
	rm -rf obj_dir
